// File: tests/job_input.txt
// Hex columns: num_cols num_rows seq_len pfb_words, then the expected
// fetch count, pfb_rden count and seq_rden count; an all-zero line ends the list
0000 0000 0001 0001 0001 0001 0005
0003 0001 0007 0004 0002 0008 0028
0002 0002 0010 0003 0003 0009 002D
0005 0000 0004 0008 0001 0008 001E
0001 0003 0040 0002 0004 0008 0028
0007 0001 0003 0010 0002 0020 0050
0000 0004 0002 0001 0005 0005 0019
0000 0000 0000 0000 0000 0000 0000

// File: files.f
logic/accel_geom_pkg.sv
logic/ctrl_pkg.sv
logic/job_sequencer.sv
logic/pfb_reader.sv
logic/seq_addr_gen.sv
logic/ce_exec_chain.sv
logic/quad_bram_ctrl.sv
tests/quad_bram_ctrl_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --assert --timing
SIM_FLAGS  ?= --binary --assert -j 0
TOP        ?= quad_bram_ctrl_tb
FILE_LIST  ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := Errors found

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qx "No errors" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/quad_bram_ctrl_tb.sv
module quad_bram_ctrl_tb;

    localparam int NUM_CE        = accel_geom_pkg::DEFAULT_NUM_AWE
                                   * accel_geom_pkg::DEFAULT_CE_PER_AWE;
    localparam int RD_LATENCY    = accel_geom_pkg::DEFAULT_SEQ_RD_LATENCY;
    localparam int READS_PER_COL = accel_geom_pkg::DEFAULT_READS_PER_COL;
    localparam int MAX_JOBS      = 16;
    localparam int JOB_FIELDS    = 7;

    logic                     clk = 1'b0;
    logic                     rst;
    accel_geom_pkg::job_cfg_t cfg;
    logic                     job_start;
    logic                     job_accept;
    logic                     fetch_request;
    logic                     fetch_ack;
    logic                     fetch_complete;
    logic                     pfb_rden;
    ctrl_pkg::seq_req_t       seq_req;
    logic [NUM_CE-1:0]        ce_execute;
    logic                     job_complete;
    logic                     job_complete_ack;

    // Seven fields per job, see the data file
    logic [15:0] job_mem [0:MAX_JOBS*JOB_FIELDS-1];

    int seed;
    int errors = 0;
    int checks = 0;
    int limit = 200;
    int cycle = 0;
    int num_jobs = 0;
    int ack_delay;
    int complete_delay;

    // Monitor bookkeeping
    int          accept_seen = 0;
    int          done_seen = 0;
    int          job_fetches = 0;
    int          job_pfb = 0;
    int          job_seq = 0;
    int          total_seq = 0;
    int          pfb_burst = 0;
    int          model_addr = 0;
    int          cur_pfb = 0;
    int          cur_seq_len = 1;
    int          ce_total [NUM_CE];
    logic        busy = 1'b0;
    logic        exp_accept = 1'b0;
    logic        fetch_req_q = 1'b0;
    logic        fetch_ack_q = 1'b0;
    logic        pfb_rden_q = 1'b0;
    logic        complete_q = 1'b0;
    logic        complete_ack_q = 1'b0;
    logic [15:0] rden_hist = '0;

    quad_bram_ctrl quad_bram_ctrl_inst (
        .clk              (clk),
        .rst              (rst),
        .cfg              (cfg),
        .job_start        (job_start),
        .job_accept       (job_accept),
        .fetch_request    (fetch_request),
        .fetch_ack        (fetch_ack),
        .fetch_complete   (fetch_complete),
        .pfb_rden         (pfb_rden),
        .seq_req          (seq_req),
        .ce_execute       (ce_execute),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack)
    );

    always #2 clk = ~clk;

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("CHECK FAILED at time %0t: %s", $time, msg);
            errors++;
        end
    endtask

    function automatic int job_field(input int job, input int idx);
        return int'(job_mem[job*JOB_FIELDS+idx]);
    endfunction

    ////////////////////
    // Responders
    ////////////////////

    // Fetch ack after 1..3 cycles, completion 1..4 cycles after that
    always begin
        @(posedge clk);
        if (!rst && fetch_request) begin
            ack_delay      = 1 + int'($unsigned($random(seed)) % 3);
            complete_delay = 1 + int'($unsigned($random(seed)) % 4);
            repeat (ack_delay) @(negedge clk);
            fetch_ack = 1'b1;
            @(negedge clk);
            fetch_ack = 1'b0;
            repeat (complete_delay - 1) @(negedge clk);
            fetch_complete = 1'b1;
            @(negedge clk);
            fetch_complete = 1'b0;
        end
    end

    always begin
        @(posedge clk);
        if (!rst && job_complete) begin
            repeat (2) @(negedge clk);
            job_complete_ack = 1'b1;
            @(negedge clk);
            job_complete_ack = 1'b0;
        end
    end

    ////////////////////
    // Monitor
    ////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            if (cycle > limit) begin
                $display("Simulation timed out waiting for the DUT after %0d cycles", limit);
                $display("Errors found");
                $finish;
            end else begin
                // Accept one cycle after a start seen in idle, never while busy
                check(job_accept == exp_accept, "job_accept does not follow an idle job_start");
                exp_accept = job_start && !busy;
                if (job_accept) begin
                    accept_seen++;
                    model_addr = 0;
                end
                if (job_start && !busy) begin
                    busy = 1'b1;
                end else if (job_complete && job_complete_ack) begin
                    busy = 1'b0;
                end

                if (fetch_request && !fetch_req_q) begin
                    job_fetches++;
                end
                check(!(fetch_request && fetch_ack_q), "fetch_request still high after fetch_ack");
                if (!fetch_request && fetch_req_q) begin
                    check(fetch_ack_q, "fetch_request dropped without fetch_ack");
                end

                // One burst of pfb_words strobes per fetched row
                if (pfb_rden) begin
                    job_pfb++;
                    pfb_burst++;
                end else if (pfb_rden_q) begin
                    check(pfb_burst == cur_pfb,
                          $sformatf("pfb burst of %0d reads, expected %0d", pfb_burst, cur_pfb));
                    pfb_burst = 0;
                end

                if (seq_req.rden) begin
                    job_seq++;
                    total_seq++;
                    check(int'(seq_req.addr) == model_addr,
                          $sformatf("sequence address %0d, expected %0d", seq_req.addr, model_addr));
                    model_addr = (model_addr + 1 == cur_seq_len) ? 0 : model_addr + 1;
                end

                // Bit 0 of the history is the current cycle
                rden_hist = {rden_hist[14:0], seq_req.rden};
                for (int i = 0; i < NUM_CE; i++) begin
                    check(ce_execute[i] == rden_hist[RD_LATENCY+i],
                          $sformatf("ce_execute[%0d] is %0b, expected %0b",
                                    i, ce_execute[i], rden_hist[RD_LATENCY+i]));
                    if (ce_execute[i]) begin
                        ce_total[i]++;
                    end
                end

                check(!(job_complete && (pfb_rden || seq_req.rden)),
                      "read strobe while job_complete is high");
                check(!(job_complete && complete_ack_q), "job_complete still high after the ack");
                if (!job_complete && complete_q) begin
                    check(complete_ack_q, "job_complete dropped without job_complete_ack");
                    done_seen++;
                end

                fetch_req_q    = fetch_request;
                fetch_ack_q    = fetch_ack;
                pfb_rden_q     = pfb_rden;
                complete_q     = job_complete;
                complete_ack_q = job_complete_ack;
            end
        end
    end

    ////////////////////
    // Job stimulus
    ////////////////////

    initial begin
        int errors_before;
        int prev_accepts;
        int prev_done;
        int rows;
        int cols;

        seed             = 47448;
        rst              = 1'b1;
        cfg              = '0;
        job_start        = 1'b0;
        fetch_ack        = 1'b0;
        fetch_complete   = 1'b0;
        job_complete_ack = 1'b0;
        for (int i = 0; i < NUM_CE; i++) begin
            ce_total[i] = 0;
        end

        $readmemh("tests/job_input.txt", job_mem);
        // Jobs run up to the all-zero end line
        for (int j = 0; j < MAX_JOBS; j++) begin
            if (num_jobs == j && job_field(j, 4) != 0) begin
                num_jobs++;
                limit += (job_field(j, 1) + 1)
                         * (job_field(j, 3) + (job_field(j, 0) + 1) * READS_PER_COL + 12);
            end
        end
        if (num_jobs == 0) begin
            $display("No jobs could be read from tests/job_input.txt");
            errors++;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check(!job_accept && !fetch_request && !pfb_rden && !seq_req.rden
              && ce_execute == '0 && !job_complete, "control outputs not low after reset");

        for (int j = 0; j < num_jobs; j++) begin
            @(negedge clk);
            errors_before = errors;
            job_fetches   = 0;
            job_pfb       = 0;
            job_seq       = 0;
            cols          = job_field(j, 0);
            rows          = job_field(j, 1);
            cur_seq_len   = job_field(j, 2);
            cur_pfb       = job_field(j, 3);
            cfg.num_cols  = job_mem[j*JOB_FIELDS][accel_geom_pkg::DIM_WIDTH-1:0];
            cfg.num_rows  = job_mem[j*JOB_FIELDS+1][accel_geom_pkg::DIM_WIDTH-1:0];
            cfg.seq_len   = job_mem[j*JOB_FIELDS+2][accel_geom_pkg::SEQ_ADDR_WIDTH-1:0];
            cfg.pfb_words = job_mem[j*JOB_FIELDS+3][accel_geom_pkg::PFB_COUNT_WIDTH-1:0];
            prev_accepts  = accept_seen;
            prev_done     = done_seen;
            job_start     = 1'b1;
            @(negedge clk);
            job_start = 1'b0;
            while (accept_seen == prev_accepts) begin
                @(negedge clk);
            end

            // Scrambled config and a second start while busy
            @(negedge clk);
            cfg       = ~cfg;
            job_start = 1'b1;
            @(negedge clk);
            job_start = 1'b0;
            while (done_seen == prev_done) begin
                @(negedge clk);
            end

            check(job_fetches == job_field(j, 4),
                  $sformatf("job %0d made %0d fetches, expected %0d", j, job_fetches,
                            job_field(j, 4)));
            check(job_pfb == job_field(j, 5),
                  $sformatf("job %0d made %0d pfb reads, expected %0d", j, job_pfb,
                            job_field(j, 5)));
            check(job_seq == job_field(j, 6),
                  $sformatf("job %0d made %0d seq reads, expected %0d", j, job_seq,
                            job_field(j, 6)));
            check(job_seq == (rows + 1) * (cols + 1) * READS_PER_COL,
                  $sformatf("job %0d seq reads do not fit its geometry", j));
            $display("Job %0d: %0d fetches, %0d pfb reads, %0d seq reads, %s", j,
                     job_fetches, job_pfb, job_seq, (errors == errors_before) ? "ok" : "FAILED");
        end

        // Let the execute chain empty
        repeat (RD_LATENCY + NUM_CE + 4) @(negedge clk);
        for (int i = 0; i < NUM_CE; i++) begin
            check(ce_total[i] == total_seq,
                  $sformatf("ce_execute[%0d] pulsed %0d times, expected %0d", i, ce_total[i],
                            total_seq));
        end

        $display("Summary: %0d jobs, %0d checks, %0d errors", num_jobs, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: logic/quad_bram_ctrl.sv
module quad_bram_ctrl #(
    parameter int NUM_AWE        = accel_geom_pkg::DEFAULT_NUM_AWE,
    parameter int CE_PER_AWE     = accel_geom_pkg::DEFAULT_CE_PER_AWE,
    parameter int SEQ_RD_LATENCY = accel_geom_pkg::DEFAULT_SEQ_RD_LATENCY,
    parameter int READS_PER_COL  = accel_geom_pkg::DEFAULT_READS_PER_COL,
    localparam int NUM_CE        = NUM_AWE * CE_PER_AWE
) (
    input  logic                     clk,
    input  logic                     rst,
    input  accel_geom_pkg::job_cfg_t cfg,
    input  logic                     job_start,
    output logic                     job_accept,
    output logic                     fetch_request,
    input  logic                     fetch_ack,
    input  logic                     fetch_complete,
    output logic                     pfb_rden,
    output ctrl_pkg::seq_req_t       seq_req,
    output logic [NUM_CE-1:0]        ce_execute,
    output logic                     job_complete,
    input  logic                     job_complete_ack
);

    accel_geom_pkg::job_cfg_t job_cfg;
    logic                     drain_start;
    logic                     drain_done;
    logic                     row_start;
    logic                     row_done;

    job_sequencer job_sequencer_inst (
        .clk              (clk),
        .rst              (rst),
        .cfg              (cfg),
        .job_start        (job_start),
        .fetch_ack        (fetch_ack),
        .fetch_complete   (fetch_complete),
        .drain_done       (drain_done),
        .row_done         (row_done),
        .job_complete_ack (job_complete_ack),
        .job_accept       (job_accept),
        .fetch_request    (fetch_request),
        .job_cfg          (job_cfg),
        .drain_start      (drain_start),
        .row_start        (row_start),
        .job_complete     (job_complete)
    );

    pfb_reader pfb_reader_inst (
        .clk         (clk),
        .rst         (rst),
        .drain_start (drain_start),
        .pfb_words   (job_cfg.pfb_words),
        .pfb_rden    (pfb_rden),
        .drain_done  (drain_done)
    );

    // Address restarts on every accepted job
    seq_addr_gen #(
        .READS_PER_COL (READS_PER_COL)
    ) seq_addr_gen_inst (
        .clk       (clk),
        .rst       (rst),
        .row_start (row_start),
        .num_cols  (job_cfg.num_cols),
        .seq_len   (job_cfg.seq_len),
        .job_begin (job_accept),
        .seq_req   (seq_req),
        .row_done  (row_done)
    );

    ce_exec_chain #(
        .NUM_CE         (NUM_CE),
        .SEQ_RD_LATENCY (SEQ_RD_LATENCY)
    ) ce_exec_chain_inst (
        .clk        (clk),
        .rst        (rst),
        .rden       (seq_req.rden),
        .ce_execute (ce_execute)
    );

endmodule

// File: logic/ce_exec_chain.sv
module ce_exec_chain #(
    parameter int NUM_CE         = accel_geom_pkg::DEFAULT_NUM_AWE
                                   * accel_geom_pkg::DEFAULT_CE_PER_AWE,
    parameter int SEQ_RD_LATENCY = accel_geom_pkg::DEFAULT_SEQ_RD_LATENCY
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rden,
    output logic [NUM_CE-1:0] ce_execute
);

    // Read latency stages first, then one stage per engine
    localparam int CHAIN_LEN = SEQ_RD_LATENCY + NUM_CE - 1;

    // Stage k holds rden delayed k+1 cycles
    logic [CHAIN_LEN-1:0] chain_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            chain_q <= '0;
        end else begin
            chain_q[0] <= rden;
            for (int i = 1; i < CHAIN_LEN; i++) begin
                chain_q[i] <= chain_q[i-1];
            end
        end
    end

    // Engine 0 taps the end of the latency line
    assign ce_execute = chain_q[CHAIN_LEN-1 -: NUM_CE];

    ////////////////////
    // Checks
    ////////////////////

    // Every sequence read reaches engine 0 after the read latency
    a_exec_latency: assert property (
        @(posedge clk) disable iff (rst) $past(rden, SEQ_RD_LATENCY) |-> ce_execute[0]
    );

endmodule

// File: logic/seq_addr_gen.sv
module seq_addr_gen #(
    parameter int READS_PER_COL = accel_geom_pkg::DEFAULT_READS_PER_COL
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      row_start,
    input  logic [accel_geom_pkg::DIM_WIDTH-1:0]      num_cols,
    input  logic [accel_geom_pkg::SEQ_ADDR_WIDTH-1:0] seq_len,
    input  logic                                      job_begin,
    output ctrl_pkg::seq_req_t                        seq_req,
    output logic                                      row_done
);

    localparam int RD_CNT_WIDTH = $clog2(READS_PER_COL + 1);

    logic [RD_CNT_WIDTH-1:0]              rd_cnt;
    logic [accel_geom_pkg::DIM_WIDTH-1:0] col;
    logic                                 col_last_rd;
    logic                                 row_last_rd;

    assign col_last_rd = (rd_cnt == RD_CNT_WIDTH'(READS_PER_COL - 1));
    assign row_last_rd = col_last_rd && (col == num_cols);

    ////////////////////
    // Row read window
    ////////////////////

    // Fixed number of reads per output column, then next column
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt       <= '0;
            col          <= '0;
            seq_req.rden <= 1'b0;
            row_done     <= 1'b0;
        end else begin
            row_done <= 1'b0;
            if (row_start) begin
                rd_cnt       <= '0;
                col          <= '0;
                seq_req.rden <= 1'b1;
            end else if (seq_req.rden) begin
                if (col_last_rd) begin
                    rd_cnt <= '0;
                    col    <= col + 1'b1;
                end else begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
                if (row_last_rd) begin
                    seq_req.rden <= 1'b0;
                    row_done     <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Sequence address
    ////////////////////

    // Wraps at seq_len and runs on across rows of one job
    always_ff @(posedge clk) begin
        if (rst || job_begin) begin
            seq_req.addr <= '0;
        end else if (seq_req.rden) begin
            if (seq_req.addr == seq_len - 1'b1) begin
                seq_req.addr <= '0;
            end else begin
                seq_req.addr <= seq_req.addr + 1'b1;
            end
        end
    end

    // Read address must lie inside the sequence table
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (rst) seq_req.rden |-> seq_req.addr < seq_len
    );

endmodule

// File: logic/pfb_reader.sv
module pfb_reader (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       drain_start,
    input  logic [accel_geom_pkg::PFB_COUNT_WIDTH-1:0] pfb_words,
    output logic                                       pfb_rden,
    output logic                                       drain_done
);

    // Words still to read, including the one strobed this cycle
    logic [accel_geom_pkg::PFB_COUNT_WIDTH-1:0] count;

    ////////////////////
    // Drain countdown
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            count      <= '0;
            pfb_rden   <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            drain_done <= 1'b0;
            if (drain_start) begin
                count    <= pfb_words;
                pfb_rden <= 1'b1;
            end else if (pfb_rden) begin
                count    <= count - 1'b1;
                // Keep reading while more than this word remains
                pfb_rden <= (count > 1);
                if (count == 1) begin
                    drain_done <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Catches a zero pfb_words or a restart mid-drain
    a_no_empty_read: assert property (
        @(posedge clk) disable iff (rst) pfb_rden |-> count != '0
    );

endmodule

// File: logic/job_sequencer.sv
module job_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  accel_geom_pkg::job_cfg_t cfg,
    input  logic                     job_start,
    input  logic                     fetch_ack,
    input  logic                     fetch_complete,
    input  logic                     drain_done,
    input  logic                     row_done,
    input  logic                     job_complete_ack,
    output logic                     job_accept,
    output logic                     fetch_request,
    output accel_geom_pkg::job_cfg_t job_cfg,
    output logic                     drain_start,
    output logic                     row_start,
    output logic                     job_complete
);

    ctrl_pkg::ctrl_state_e                 state;
    logic [accel_geom_pkg::DIM_WIDTH-1:0]  row;
    logic                                  fetch_acked;

    ////////////////////
    // Job configuration
    ////////////////////

    // Captured once per job so the host may reload cfg
    always_ff @(posedge clk) begin
        if (state == ctrl_pkg::IDLE && job_start) begin
            job_cfg <= cfg;
        end
    end

    ////////////////////
    // Main FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ctrl_pkg::IDLE;
            row           <= '0;
            fetch_acked   <= 1'b0;
            job_accept    <= 1'b0;
            fetch_request <= 1'b0;
            drain_start   <= 1'b0;
            row_start     <= 1'b0;
            job_complete  <= 1'b0;
        end else begin
            // Strobes last one cycle
            job_accept  <= 1'b0;
            drain_start <= 1'b0;
            row_start   <= 1'b0;

            case (state)
                ctrl_pkg::IDLE: begin
                    if (job_start) begin
                        job_accept    <= 1'b1;
                        fetch_request <= 1'b1;
                        row           <= '0;
                        state         <= ctrl_pkg::FETCH;
                    end
                end

                ctrl_pkg::FETCH: begin
                    // Request drops the cycle after the ack
                    if (fetch_ack && !fetch_acked) begin
                        fetch_request <= 1'b0;
                        fetch_acked   <= 1'b1;
                    end
                    // Completion counts only once the fetch was acked
                    if (fetch_complete && (fetch_acked || fetch_ack)) begin
                        fetch_request <= 1'b0;
                        fetch_acked   <= 1'b0;
                        drain_start   <= 1'b1;
                        state         <= ctrl_pkg::DRAIN;
                    end
                end

                ctrl_pkg::DRAIN: begin
                    if (drain_done) begin
                        row_start <= 1'b1;
                        state     <= ctrl_pkg::EXECUTE;
                    end
                end

                ctrl_pkg::EXECUTE: begin
                    if (row_done) begin
                        if (row == job_cfg.num_rows) begin
                            job_complete <= 1'b1;
                            state        <= ctrl_pkg::DONE;
                        end else begin
                            // Next input row, strictly after this one
                            row           <= row + 1'b1;
                            fetch_request <= 1'b1;
                            state         <= ctrl_pkg::FETCH;
                        end
                    end
                end

                ctrl_pkg::DONE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ctrl_pkg::IDLE;
                    end
                end

                default: begin
                    state <= ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Fetch and completion handshakes never overlap
    a_req_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(fetch_request && job_complete)
    );

    // Sequence reads end only while a row executes
    a_row_done_in_exec: assert property (
        @(posedge clk) disable iff (rst) row_done |-> state == ctrl_pkg::EXECUTE
    );

endmodule

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

    ////////////////////
    // Controller FSM
    ////////////////////

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FETCH   = 3'd1,
        DRAIN   = 3'd2,
        EXECUTE = 3'd3,
        DONE    = 3'd4
    } ctrl_state_e;

    ////////////////////
    // Sequence BRAM port
    ////////////////////

    // Read request, 13 bits
    typedef struct packed {
        logic                                      rden;
        logic [accel_geom_pkg::SEQ_ADDR_WIDTH-1:0] addr;
    } seq_req_t;

endpackage

// File: logic/accel_geom_pkg.sv
package accel_geom_pkg;

    ////////////////////
    // Field widths
    ////////////////////

    // Row and column counts and indices
    parameter int DIM_WIDTH       = 9;
    parameter int SEQ_ADDR_WIDTH  = 12;
    parameter int PFB_COUNT_WIDTH = 9;

    ////////////////////
    // Default sizes
    ////////////////////

    parameter int DEFAULT_NUM_AWE        = 4;
    parameter int DEFAULT_CE_PER_AWE     = 2;
    parameter int DEFAULT_SEQ_RD_LATENCY = 3;
    parameter int DEFAULT_READS_PER_COL  = 5;

    // One job, 39 bits
    typedef struct packed {
        logic [DIM_WIDTH-1:0]       num_cols;   // last column index
        logic [DIM_WIDTH-1:0]       num_rows;   // last row index
        logic [SEQ_ADDR_WIDTH-1:0]  seq_len;    // wrap length, at least 1
        logic [PFB_COUNT_WIDTH-1:0] pfb_words;  // words per fetched row, at least 1
    } job_cfg_t;

endpackage
